// File: hw/align_buffer_top.sv
//////////////////////////////////////////////////
// Instruction alignment buffer top level
//////////////////////////////////////////////////

`timescale 1ns/10ps

module align_buffer_top import isa_pkg::*; import fetch_pkg::*; #(
  parameter int unsigned BUF_DEPTH = DEF_BUF_DEPTH
) (
  input  logic  clk,
  input  logic  rst_n,

  // Control
  input  logic  fetch_en_i,
  input  logic  branch_i,
  input  addr_t branch_addr_i,

  // Memory request
  output logic  req_valid_o,
  output addr_t req_addr_o,
  input  logic  req_ready_i,

  // Memory response
  input  logic  resp_valid_i,
  input  word_t resp_rdata_i,
  input  logic  resp_err_i,

  // Instruction output
  output logic  instr_valid_o,
  input  logic  instr_ready_i,
  output word_t instr_o,
  output addr_t instr_addr_o,
  output logic  instr_err_o
);

  logic       resp_keep;
  logic       pop;
  instr_cnt_t buf_cnt;

  fetch_req_ctrl u_req_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_en_i    (fetch_en_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .buf_cnt_i     (buf_cnt),
    .req_ready_i   (req_ready_i),
    .resp_valid_i  (resp_valid_i),
    .req_valid_o   (req_valid_o),
    .req_addr_o    (req_addr_o),
    .resp_keep_o   (resp_keep)
  );

  instr_counter #(
    .BUF_DEPTH (BUF_DEPTH)
  ) u_instr_counter (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .resp_keep_i   (resp_keep),
    .resp_rdata_i  (resp_rdata_i),
    .pop_i         (pop),
    .buf_cnt_o     (buf_cnt)
  );

  align_fifo #(
    .BUF_DEPTH (BUF_DEPTH)
  ) u_align_fifo (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .resp_keep_i   (resp_keep),
    .resp_rdata_i  (resp_rdata_i),
    .resp_err_i    (resp_err_i),
    .instr_ready_i (instr_ready_i),
    .instr_valid_o (instr_valid_o),
    .instr_o       (instr_o),
    .instr_addr_o  (instr_addr_o),
    .instr_err_o   (instr_err_o),
    .pop_o         (pop)
  );

endmodule

// File: hw/align_fifo.sv
//////////////////////////////////////////////////
// Alignment FIFO: stores fetched words and hands
// out 16/32-bit instructions at halfword addresses
//////////////////////////////////////////////////

`timescale 1ns/10ps

module align_fifo import isa_pkg::*; import fetch_pkg::*; #(
  parameter int unsigned BUF_DEPTH = 3
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  branch_i,
  input  addr_t branch_addr_i,

  // Kept memory response
  input  logic  resp_keep_i,
  input  word_t resp_rdata_i,
  input  logic  resp_err_i,

  // Instruction port
  input  logic  instr_ready_i,
  output logic  instr_valid_o,
  output word_t instr_o,
  output addr_t instr_addr_o,
  output logic  instr_err_o,

  // One instruction taken this cycle
  output logic  pop_o
);

  localparam int unsigned PTR_W = $clog2(BUF_DEPTH);

  // Word storage, no reset needed on payload
  word_t              mem_q [BUF_DEPTH];
  logic [BUF_DEPTH-1:0] err_q;
  logic [BUF_DEPTH-1:0] valid_q;
  logic [BUF_DEPTH-1:0] valid_n;

  logic [PTR_W-1:0]   rptr_q;
  logic [PTR_W-1:0]   rptr_n;
  logic [PTR_W-1:0]   rptr2;
  logic [PTR_W-1:0]   wptr_q;

  addr_t              addr_q;
  addr_t              addr_n;
  addr_t              addr_incr;

  // Read side sources
  word_t              word_a;
  logic               err_a;
  logic               avail_a;
  logic [HALF_W-1:0]  half_b;
  logic               err_b;
  logic               avail_b;
  logic               lo_compr;
  logic               hi_compr;
  logic               free_entry;

  // Circular increment
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  assign rptr2 = ptr_inc(rptr_q);

  //////////////////////////////////////////////////
  // Read side and realignment
  //////////////////////////////////////////////////

  // First word, bypassed from the bus when the entry is empty
  assign word_a  = valid_q[rptr_q] ? mem_q[rptr_q] : resp_rdata_i;
  assign err_a   = valid_q[rptr_q] ? err_q[rptr_q] : resp_err_i;
  assign avail_a = valid_q[rptr_q] || resp_keep_i;

  // Lower half of the following word
  assign half_b  = valid_q[rptr2] ? mem_q[rptr2][HALF_W-1:0] : resp_rdata_i[HALF_W-1:0];
  assign err_b   = valid_q[rptr2] ? err_q[rptr2] : resp_err_i;
  // Second half needs the first entry stored already
  assign avail_b = valid_q[rptr2] || (valid_q[rptr_q] && resp_keep_i);

  assign lo_compr = is_compressed(word_a[HALF_W-1:0]);
  assign hi_compr = is_compressed(word_a[XLEN-1:HALF_W]);

  always_comb begin
    if (addr_q[1]) begin
      instr_o     = {half_b, word_a[XLEN-1:HALF_W]};
      instr_err_o = hi_compr ? err_a : (err_a || err_b);
      // Straddling instructions wait for their second word
      instr_valid_o = !branch_i && avail_a && (hi_compr || avail_b);
    end else begin
      instr_o       = word_a;
      instr_err_o   = err_a;
      instr_valid_o = !branch_i && avail_a;
    end
  end

  assign instr_addr_o = addr_q;
  assign pop_o        = instr_valid_o && instr_ready_i;

  //////////////////////////////////////////////////
  // Pointer, address and valid updates
  //////////////////////////////////////////////////

  assign addr_incr = {addr_q[XLEN-1:2], 2'b00} + addr_t'(WORD_BYTES);

  // Only an aligned compressed instruction keeps the entry
  assign free_entry = addr_q[1] || !lo_compr;

  always_comb begin
    addr_n = addr_q;
    rptr_n = rptr_q;
    if (pop_o) begin
      if (addr_q[1]) begin
        // Uncompressed tail leaves us mid-word in the next entry
        addr_n = {addr_incr[XLEN-1:2], hi_compr ? 2'b00 : 2'b10};
      end else if (lo_compr) begin
        addr_n = {addr_q[XLEN-1:2], 2'b10};
      end else begin
        addr_n = addr_incr;
      end
      if (free_entry) begin
        rptr_n = rptr2;
      end
    end
  end

  always_comb begin
    valid_n = valid_q;
    if (resp_keep_i) begin
      valid_n[wptr_q] = 1'b1;
    end
    // A bypassed word is written and freed in one cycle
    if (pop_o && free_entry) begin
      valid_n[rptr_q] = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      rptr_q  <= '0;
      wptr_q  <= '0;
      addr_q  <= '0;
    end else if (branch_i) begin
      // Kill contents and restart at the target
      valid_q <= '0;
      rptr_q  <= '0;
      wptr_q  <= '0;
      addr_q  <= {branch_addr_i[XLEN-1:1], 1'b0};
    end else begin
      valid_q <= valid_n;
      rptr_q  <= rptr_n;
      addr_q  <= addr_n;
      if (resp_keep_i) begin
        wptr_q <= ptr_inc(wptr_q);
      end
    end
  end

  // Payload write
  always_ff @(posedge clk) begin
    if (resp_keep_i && !branch_i) begin
      mem_q[wptr_q] <= resp_rdata_i;
      err_q[wptr_q] <= resp_err_i;
    end
  end

  // Request rule must never let the FIFO overflow
  a_no_overwrite: assert property (@(posedge clk) disable iff (!rst_n)
    resp_keep_i |-> !valid_q[wptr_q]);

endmodule

// File: hw/fetch_pkg.sv
//////////////////////////////////////////////////
// Fetch buffer types and constants
//////////////////////////////////////////////////

package fetch_pkg;
  import isa_pkg::*;

  // Default number of words in the alignment FIFO
  localparam int unsigned DEF_BUF_DEPTH = 3;

  // Requests in flight, fixed by the request rule
  localparam int unsigned MAX_OUTSTANDING = 2;

  // Bytes per fetched word, the request address step
  localparam int unsigned WORD_BYTES = XLEN / 8;

  // Instruction count width
  // 8 bits covers twice any practical FIFO depth
  localparam int unsigned CNT_W = 8;

  // Write side alignment of the next incoming word
  typedef enum logic [1:0] {
    // Next word starts with an instruction
    ALIGN_WORD      = 2'd0,
    // Halfword branch target, lower half of next word is dropped
    ALIGN_HALF_SKIP = 2'd1,
    // Lower half of next word ends an uncompressed instruction
    ALIGN_HALF_TAIL = 2'd2
  } align_state_e;

  // Complete instructions held in the buffer
  typedef logic [CNT_W-1:0] instr_cnt_t;

  // Outstanding or flush count
  typedef logic [1:0] txn_cnt_t;

endpackage

// File: hw/fetch_req_ctrl.sv
//////////////////////////////////////////////////
// Fetch request control: request rule, address
// generation, outstanding and flush tracking
//////////////////////////////////////////////////

`timescale 1ns/10ps

module fetch_req_ctrl import isa_pkg::*; import fetch_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,

  // Control
  input  logic       fetch_en_i,
  input  logic       branch_i,
  input  addr_t      branch_addr_i,

  // Instruction count from the write side
  input  instr_cnt_t buf_cnt_i,

  // Memory request and response handshake
  input  logic       req_ready_i,
  input  logic       resp_valid_i,
  output logic       req_valid_o,
  output addr_t      req_addr_o,

  // Response belongs to the current stream
  output logic       resp_keep_o
);

  // Outstanding requests and responses still to drop
  txn_cnt_t out_cnt_q;
  txn_cnt_t out_cnt_n;
  txn_cnt_t flush_cnt_q;
  txn_cnt_t flush_cnt_n;

  // Next sequential word address
  addr_t    addr_q;
  addr_t    addr_n;

  // Set by the first branch, no fetching before it
  logic     started_q;

  logic     req_accept;
  logic     need_word;

  //////////////////////////////////////////////////
  // Request rule
  //////////////////////////////////////////////////

  // Buffer nearly empty, or a redirect
  assign need_word = branch_i ||
                     (buf_cnt_i == '0) ||
                     ((buf_cnt_i == instr_cnt_t'(1)) && (out_cnt_q == '0));

  assign req_valid_o = fetch_en_i &&
                       (branch_i || started_q) &&
                       (out_cnt_q < txn_cnt_t'(MAX_OUTSTANDING)) &&
                       need_word;

  // Branch target goes out in the same cycle, word aligned
  assign req_addr_o = branch_i ? {branch_addr_i[XLEN-1:2], 2'b00} : addr_q;

  assign req_accept = req_valid_o && req_ready_i;

  // Responses in the branch cycle are always from before the branch
  assign resp_keep_o = resp_valid_i && !branch_i && (flush_cnt_q == '0);

  //////////////////////////////////////////////////
  // Counters and address
  //////////////////////////////////////////////////

  always_comb begin
    out_cnt_n = out_cnt_q;
    if (req_accept && !resp_valid_i) begin
      out_cnt_n = out_cnt_q + txn_cnt_t'(1);
    end else if (!req_accept && resp_valid_i) begin
      out_cnt_n = out_cnt_q - txn_cnt_t'(1);
    end
  end

  always_comb begin
    flush_cnt_n = flush_cnt_q;
    if (branch_i) begin
      // Everything in flight is stale, except a response landing now
      flush_cnt_n = out_cnt_q - txn_cnt_t'(resp_valid_i);
    end else if (resp_valid_i && (flush_cnt_q != '0)) begin
      flush_cnt_n = flush_cnt_q - txn_cnt_t'(1);
    end
  end

  always_comb begin
    addr_n = addr_q;
    if (req_accept) begin
      addr_n = req_addr_o + addr_t'(WORD_BYTES);
    end else if (branch_i) begin
      // Redirect even if the memory did not take the request
      addr_n = {branch_addr_i[XLEN-1:2], 2'b00};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_cnt_q   <= '0;
      flush_cnt_q <= '0;
      addr_q      <= '0;
      started_q   <= 1'b0;
    end else begin
      out_cnt_q   <= out_cnt_n;
      flush_cnt_q <= flush_cnt_n;
      addr_q      <= addr_n;
      if (branch_i) begin
        started_q <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  // Request rule keeps at most two in flight
  a_out_max: assert property (@(posedge clk) disable iff (!rst_n)
    out_cnt_q <= txn_cnt_t'(MAX_OUTSTANDING));

  // Memory only answers accepted requests
  a_no_orphan_resp: assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid_i |-> (out_cnt_q != '0));

endmodule

// File: hw/instr_counter.sv
//////////////////////////////////////////////////
// Instruction counter: alignment of incoming words
// and count of complete instructions in the FIFO
//////////////////////////////////////////////////

`timescale 1ns/10ps

module instr_counter import isa_pkg::*; import fetch_pkg::*; #(
  parameter int unsigned BUF_DEPTH = 3
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       branch_i,
  input  addr_t      branch_addr_i,
  input  logic       resp_keep_i,
  input  word_t      resp_rdata_i,
  input  logic       pop_i,
  output instr_cnt_t buf_cnt_o
);

  align_state_e state_q;
  align_state_e state_n;

  // Instructions completed by the incoming word, 0 to 2
  logic [1:0]   n_done;

  instr_cnt_t   cnt_q;
  instr_cnt_t   cnt_n;

  // Pop from last cycle, subtracted one cycle late
  logic         pop_q;

  logic         lo_compr;
  logic         hi_compr;

  assign lo_compr = is_compressed(resp_rdata_i[HALF_W-1:0]);
  assign hi_compr = is_compressed(resp_rdata_i[XLEN-1:HALF_W]);

  // Completions and next alignment for one kept word
  always_comb begin
    state_n = state_q;
    n_done  = 2'd0;
    if (branch_i) begin
      state_n = branch_addr_i[1] ? ALIGN_HALF_SKIP : ALIGN_WORD;
    end else if (resp_keep_i) begin
      case (state_q)
        ALIGN_WORD: begin
          if (!lo_compr) begin
            // One full word instruction
            n_done = 2'd1;
          end else if (hi_compr) begin
            n_done = 2'd2;
          end else begin
            // Upper half opens a straddling instruction
            n_done  = 2'd1;
            state_n = ALIGN_HALF_TAIL;
          end
        end
        ALIGN_HALF_SKIP: begin
          // Lower half is before the branch target
          n_done  = hi_compr ? 2'd1 : 2'd0;
          state_n = hi_compr ? ALIGN_WORD : ALIGN_HALF_TAIL;
        end
        ALIGN_HALF_TAIL: begin
          // Lower half always finishes the pending one
          n_done  = hi_compr ? 2'd2 : 2'd1;
          state_n = hi_compr ? ALIGN_WORD : ALIGN_HALF_TAIL;
        end
        default: begin
          state_n = ALIGN_WORD;
        end
      endcase
    end
  end

  // Clear on branch, else add new ones and drop last cycle's pop
  assign cnt_n = branch_i ? '0 :
                 cnt_q + instr_cnt_t'(n_done) - instr_cnt_t'(pop_q);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ALIGN_WORD;
      cnt_q   <= '0;
      pop_q   <= 1'b0;
    end else begin
      state_q <= state_n;
      cnt_q   <= cnt_n;
      pop_q   <= pop_i;
    end
  end

  // Count as seen by the request rule
  assign buf_cnt_o = cnt_q - instr_cnt_t'(pop_q);

  // Count stays within two instructions per FIFO word
  a_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
    cnt_q <= instr_cnt_t'(2 * BUF_DEPTH));

endmodule

// File: hw/isa_pkg.sv
//////////////////////////////////////////////////
// RISC-V instruction set facts used by the fetch
// path: word and halfword widths, compressed rule
//////////////////////////////////////////////////

package isa_pkg;

  // Address and fetch word width
  localparam int unsigned XLEN = 32;

  // Width of one parcel of a compressed instruction
  localparam int unsigned HALF_W = 16;

  // Low opcode bits of an uncompressed instruction
  localparam logic [1:0] OPC_FULL = 2'b11;

  // One fetched instruction word
  typedef logic [XLEN-1:0] word_t;

  // Byte address
  typedef logic [XLEN-1:0] addr_t;

  // A parcel starts a compressed instruction when its low bits are not OPC_FULL
  function automatic logic is_compressed(input logic [HALF_W-1:0] half);
    return half[1:0] != OPC_FULL;
  endfunction

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the alignment buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
  -f sim.f \
  --top-module tb_align_buffer \
  -Mdir obj_dir -o tb_align_buffer
if [ $? -ne 0 ]; then
  echo "Verilator build did not succeed"
  exit 1
fi

./obj_dir/tb_align_buffer | tee "$LOG"
status=${PIPESTATUS[0]}
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: sim.f
hw/isa_pkg.sv
hw/fetch_pkg.sv
hw/fetch_req_ctrl.sv
hw/instr_counter.sv
hw/align_fifo.sv
hw/align_buffer_top.sv
sim/tb_imem.sv
sim/tb_align_buffer.sv

// File: sim/tb_align_buffer.sv
//////////////////////////////////////////////////
// Testbench for the instruction alignment buffer
//////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_align_buffer import isa_pkg::*; ();

  localparam int    NUM_TESTS  = 6;
  localparam addr_t DECOY_ADDR = 32'h0000_0080;

  //////////////////////////////////////////////////
  // Test table
  //////////////////////////////////////////////////

  // Name, branch target, instructions taken, ready pattern, decoy first
  string       t_name   [NUM_TESTS] = '{"aligned_seq", "half_target", "half_straddle",
                                        "branch_inflight", "error_words", "ready_stall"};
  addr_t       t_target [NUM_TESTS] = '{32'h00, 32'h2e, 32'h0e, 32'h40, 32'h20, 32'h04};
  int          t_count  [NUM_TESTS] = '{40, 20, 16, 24, 30, 60};
  logic [15:0] t_ready  [NUM_TESTS] = '{16'hffff, 16'hffff, 16'hffff, 16'hffff, 16'hffff,
                                        16'b1011_0011_1010_0110};
  bit          t_decoy  [NUM_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1};

  logic  clk;
  logic  rst_n;
  logic  fetch_en_i;
  logic  branch_i;
  addr_t branch_addr_i;
  logic  req_valid_o;
  addr_t req_addr_o;
  logic  req_ready_i;
  logic  resp_valid_i;
  word_t resp_rdata_i;
  logic  resp_err_i;
  logic  instr_valid_o;
  logic  instr_ready_i;
  word_t instr_o;
  addr_t instr_addr_o;
  logic  instr_err_o;

  int    err_cnt = 0;
  int    bad_tests = 0;
  int    out_cnt = 0;
  int    cyc_cnt = 0;
  int    cyc_limit;
  string cur_name = "reset_idle";

  // Last stalled instruction that must hold until taken
  logic  held = 1'b0;
  word_t held_instr;
  word_t held_mask;
  addr_t held_addr;
  logic  held_err;

  // Request address model
  addr_t next_req_addr = '0;
  addr_t exp_req_addr;

  align_buffer_top uut (
    .clk           (clk),
    .rst_n         (rst_n),
    .fetch_en_i    (fetch_en_i),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .req_valid_o   (req_valid_o),
    .req_addr_o    (req_addr_o),
    .req_ready_i   (req_ready_i),
    .resp_valid_i  (resp_valid_i),
    .resp_rdata_i  (resp_rdata_i),
    .resp_err_i    (resp_err_i),
    .instr_valid_o (instr_valid_o),
    .instr_ready_i (instr_ready_i),
    .instr_o       (instr_o),
    .instr_addr_o  (instr_addr_o),
    .instr_err_o   (instr_err_o)
  );

  tb_imem u_imem (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (req_valid_o),
    .req_addr_i   (req_addr_o),
    .req_ready_o  (req_ready_i),
    .resp_valid_o (resp_valid_i),
    .resp_rdata_o (resp_rdata_i),
    .resp_err_o   (resp_err_i)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // Compare tasks and reference model
  //////////////////////////////////////////////////

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("Error: %s expected %h actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (exp !== act) begin
      $display("Error: %s expected %h actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Error: %s expected %b actual %b", name, exp, act);
      err_cnt++;
    end
  endtask

  // Halfword of the program image at a byte address
  function automatic logic [15:0] image_half(input addr_t a);
    word_t w;
    w = u_imem.image[a[7:2]];
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  function automatic logic image_err(input addr_t a);
    return u_imem.err_flag[a[7:2]];
  endfunction

  //////////////////////////////////////////////////
  // Bus monitor for requests and held outputs
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!rst_n) begin
      out_cnt       = 0;
      held          = 1'b0;
      next_req_addr = '0;
    end else begin
      if (req_valid_o && (out_cnt == 2)) begin
        $display("%s: request issued while two requests are outstanding", cur_name);
        err_cnt++;
      end
      // A redirect requests its target at once unless two are in flight
      if (branch_i && fetch_en_i && (out_cnt < 2)) begin
        check_bit({cur_name, " branch req_valid"}, 1'b1, req_valid_o);
      end
      // Branch cycles request the aligned target and all others the next word
      exp_req_addr = branch_i ? {branch_addr_i[XLEN-1:2], 2'b00} : next_req_addr;
      if (req_valid_o) begin
        check_addr({cur_name, " req_addr"}, exp_req_addr, req_addr_o);
      end
      if (req_valid_o && req_ready_i) begin
        next_req_addr = exp_req_addr + 32'd4;
      end else if (branch_i) begin
        next_req_addr = exp_req_addr;
      end
      // Count after the coming edge
      if (req_valid_o && req_ready_i) begin
        out_cnt++;
      end
      if (resp_valid_i) begin
        out_cnt--;
      end
      // A branch may legally drop a stalled instruction
      if (held && !branch_i) begin
        check_bit({cur_name, " held valid"}, 1'b1, instr_valid_o);
        check_word({cur_name, " held instr"}, held_instr, instr_o & held_mask);
        check_addr({cur_name, " held addr"}, held_addr, instr_addr_o);
        check_bit({cur_name, " held err"}, held_err, instr_err_o);
      end
      held       = instr_valid_o && !instr_ready_i && !branch_i;
      held_mask  = (instr_o[1:0] == OPC_FULL) ? 32'hffff_ffff : 32'h0000_ffff;
      held_instr = instr_o & held_mask;
      held_addr  = instr_addr_o;
      held_err   = instr_err_o;
    end
  end

  //////////////////////////////////////////////////
  // Test sequences
  //////////////////////////////////////////////////

  task automatic idle_check();
    int errs_before;
    errs_before = err_cnt;
    repeat (20) begin
      @(negedge clk);
      check_bit("reset_idle req_valid", 1'b0, req_valid_o);
      check_bit("reset_idle instr_valid", 1'b0, instr_valid_o);
    end
    if (err_cnt != errs_before) begin
      bad_tests++;
    end
    $display("reset_idle: 20 cycles without branch, %0d errors", err_cnt - errs_before);
  endtask

  task automatic run_test(input int idx);
    addr_t       exp_addr;
    logic [15:0] lo;
    word_t       exp_w;
    word_t       mask;
    logic        exp_e;
    int          taken;
    int          errs_before;
    logic [3:0]  phase;
    errs_before = err_cnt;
    cur_name    = t_name[idx];
    @(posedge clk);
    #1;
    instr_ready_i = 1'b0;
    if (t_decoy[idx]) begin
      // Keep redirecting to the decoy until two fetches are in flight
      branch_i      = 1'b1;
      branch_addr_i = DECOY_ADDR;
      @(posedge clk);
      #1;
      while (out_cnt != 2) begin
        @(posedge clk);
        #1;
      end
    end
    branch_i      = 1'b1;
    branch_addr_i = t_target[idx];
    @(posedge clk);
    #1;
    branch_i = 1'b0;
    exp_addr = t_target[idx];
    taken    = 0;
    phase    = '0;
    while (taken < t_count[idx]) begin
      instr_ready_i = t_ready[idx][phase];
      phase         = phase + 4'd1;
      @(negedge clk);
      if (instr_valid_o && instr_ready_i) begin
        lo = image_half(exp_addr);
        if (lo[1:0] != OPC_FULL) begin
          // Only the low half of a compressed one is compared
          exp_w = {16'h0000, lo};
          mask  = 32'h0000_ffff;
          exp_e = image_err(exp_addr);
        end else begin
          exp_w = {image_half(exp_addr + 32'd2), lo};
          mask  = 32'hffff_ffff;
          exp_e = image_err(exp_addr) || image_err(exp_addr + 32'd2);
        end
        check_word($sformatf("%s instr %0d", cur_name, taken), exp_w, instr_o & mask);
        check_addr($sformatf("%s addr %0d", cur_name, taken), exp_addr, instr_addr_o);
        check_bit($sformatf("%s err %0d", cur_name, taken), exp_e, instr_err_o);
        exp_addr = exp_addr + ((mask == 32'hffff_ffff) ? 32'd4 : 32'd2);
        taken++;
      end
      @(posedge clk);
      #1;
    end
    instr_ready_i = 1'b0;
    if (err_cnt != errs_before) begin
      bad_tests++;
    end
    $display("%s: %0d instructions checked, %0d errors", cur_name, taken,
             err_cnt - errs_before);
  endtask

  // Watchdog sized from the table at 200 cycles per instruction
  initial begin
    cyc_limit = 100;
    foreach (t_count[i]) begin
      cyc_limit += 200 * t_count[i];
    end
    while (cyc_cnt < cyc_limit) begin
      @(posedge clk);
      cyc_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles", cyc_limit);
    $display("Test failed");
    $finish;
  end

  initial begin
    rst_n         = 1'b0;
    fetch_en_i    = 1'b0;
    branch_i      = 1'b0;
    branch_addr_i = '0;
    instr_ready_i = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_n      = 1'b1;
    fetch_en_i = 1'b1;
    idle_check();
    for (int i = 0; i < NUM_TESTS; i++) begin
      run_test(i);
    end
    $display("Summary: %0d tests, %0d with errors, %0d errors in total",
             NUM_TESTS + 1, bad_tests, err_cnt);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: sim/tb_imem.sv
//////////////////////////////////////////////////
// Instruction memory model for the testbench,
// random acceptance and 1 to 3 cycle latency
//////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_imem import isa_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  req_valid_i,
  input  addr_t req_addr_i,
  output logic  req_ready_o,
  output logic  resp_valid_o,
  output word_t resp_rdata_o,
  output logic  resp_err_o
);

  // 64 word program image and per-word bus error flags
  word_t       image [64];
  logic        err_flag [64];

  // Accepted requests waiting for their response, in order
  addr_t       q_addr [$];
  int          q_due [$];

  logic [31:0] lfsr_q;
  logic        accept;
  int          cyc;
  int          lat;

  // 32-bit Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One random bit per call
  function automatic logic take_bit();
    lfsr_q = lfsr_step(lfsr_q);
    return lfsr_q[0];
  endfunction

  // Halfword carries its own index, so stale or shifted data never matches
  // About two in five parcels open an uncompressed instruction
  function automatic logic [15:0] half_pattern(input int unsigned i);
    logic [6:0] idx;
    logic [1:0] lo;
    idx = 7'(i);
    lo  = (((i * 3) % 5) < 2) ? 2'b11 : 2'(i % 3);
    return {idx, idx ^ 7'h5a, lo};
  endfunction

  initial begin
    lfsr_q       = 32'd78924;
    cyc          = 0;
    req_ready_o  = 1'b0;
    resp_valid_o = 1'b0;
    resp_rdata_o = '0;
    resp_err_o   = 1'b0;
    for (int unsigned w = 0; w < 64; w++) begin
      image[w]    = {half_pattern(2 * w + 1), half_pattern(2 * w)};
      err_flag[w] = (w % 10) == 9;
    end
    forever begin
      // Handshake is stable half a cycle before the edge
      @(negedge clk);
      accept = rst_n && req_valid_i && req_ready_o;
      @(posedge clk);
      cyc++;
      if (accept) begin
        lat = 1;
        if (take_bit()) lat++;
        if (take_bit()) lat++;
        q_addr.push_back(req_addr_i);
        q_due.push_back(cyc + lat - 1);
      end
      #1;
      // At most one response per cycle, never back-pressured
      if ((q_due.size() > 0) && (q_due[0] <= cyc)) begin
        resp_valid_o = 1'b1;
        resp_rdata_o = image[q_addr[0][7:2]];
        resp_err_o   = err_flag[q_addr[0][7:2]];
        void'(q_addr.pop_front());
        void'(q_due.pop_front());
      end else begin
        resp_valid_o = 1'b0;
        resp_rdata_o = '0;
        resp_err_o   = 1'b0;
      end
      req_ready_o = rst_n && take_bit();
    end
  end

endmodule
